// File: hdl/prio_select.sv
// Priority selector, lowest index first
// Returns up to NUM_GRANTS request indexes with valid flags

`timescale 1ns/10ps

module prio_select #(
	parameter int WIDTH      = 8,
	parameter int NUM_GRANTS = 2
) (
	input  logic [WIDTH-1:0]                           req,
	output logic [NUM_GRANTS-1:0][$clog2(WIDTH)-1:0]   grant_idx,
	output logic [NUM_GRANTS-1:0]                      grant_valid
);

	//////////////////////////////////////////////////////////////////////
	// Iterative pick
	//////////////////////////////////////////////////////////////////////

	// Each stage takes the lowest set bit of the remaining requests,
	// encodes it, then removes it for the next stage
	always_comb begin
		logic [WIDTH-1:0] remain;
		logic [WIDTH-1:0] lowest;

		remain      = req;
		grant_idx   = '0;
		grant_valid = '0;

		for (int g = 0; g < NUM_GRANTS; g++) begin
			// Isolate lowest set bit
			lowest = remain & (-remain);

			grant_valid[g] = |lowest;

			// One-hot to index
			for (int i = 0; i < WIDTH; i++) begin
				if (lowest[i]) begin
					grant_idx[g] = i[$clog2(WIDTH)-1:0];
				end
			end

			remain = remain & ~lowest;
		end
	end

endmodule

// File: hdl/reservation_station.sv
// Reservation station core
// Entry table, dispatch placement, CDB wakeup, per-type issue select,
// registered issue ports and flush

`timescale 1ns/10ps

module reservation_station (
	input  logic                                              clock,
	input  logic                                              rst_n,
	input  logic                                              flush,
	input  logic                                              issue_en,
	input  rs_pkg::dispatch_slot_t [rs_pkg::DISPATCH_WIDTH-1:0] dispatch,
	input  rs_pkg::cdb_lane_t [rs_pkg::CDB_WIDTH-1:0]           cdb,
	output logic [rs_pkg::DISPATCH_WIDTH-1:0]                   dispatch_accept,
	output rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0]         issue,
	output logic [rs_pkg::COUNT_BITS-1:0]                       free_count
);

	// Table state, busy kept apart from the payload
	logic [rs_pkg::RS_SIZE-1:0]                busy_q;
	logic [rs_pkg::RS_SIZE-1:0]                busy_next;
	rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0]   rs_table;
	rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0]   rs_table_next;

	// Wakeup
	logic [rs_pkg::RS_SIZE-1:0][1:0][rs_pkg::TAG_BITS-1:0] cam_tags;
	logic [rs_pkg::RS_SIZE-1:0][1:0]                       cam_hits;
	logic [rs_pkg::RS_SIZE-1:0]                            entry_ready;

	// Dispatch placement
	logic [rs_pkg::RS_SIZE-1:0]                                free_vec;
	logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::IDX_BITS-1:0]   disp_idx;
	logic [rs_pkg::DISPATCH_WIDTH-1:0]                         disp_valid;
	logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::IDX_BITS-1:0]   slot_idx;

	// Issue select and registers
	logic [rs_pkg::NUM_FU_TYPES-1:0][rs_pkg::RS_SIZE-1:0]      issue_req;
	logic [rs_pkg::NUM_ISSUE-1:0][rs_pkg::IDX_BITS-1:0]        sel_idx;
	logic [rs_pkg::NUM_ISSUE-1:0]                              sel_valid;
	rs_pkg::rs_entry_t [rs_pkg::NUM_ISSUE-1:0]                 issue_entry_next;
	rs_pkg::rs_entry_t [rs_pkg::NUM_ISSUE-1:0]                 issue_entry_q;
	logic [rs_pkg::NUM_ISSUE-1:0]                              issue_valid_q;
	logic [rs_pkg::COUNT_BITS-1:0]                             free_next;

	//////////////////////////////////////////////////////////////////////
	// Wakeup
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			cam_tags[i][0] = rs_table[i].src1.tag;
			cam_tags[i][1] = rs_table[i].src2.tag;
		end
	end

	tag_cam #(
		.ENTRIES (rs_pkg::RS_SIZE),
		.LANES   (rs_pkg::CDB_WIDTH)
	) wakeup_cam (
		.entry_tags (cam_tags),
		.cdb        (cdb),
		.hits       (cam_hits)
	);

	// Bypass: a hit this cycle counts as ready right away
	always_comb begin
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			entry_ready[i] = busy_q[i] & issue_en
				& (rs_table[i].src1.ready | cam_hits[i][0])
				& (rs_table[i].src2.ready | cam_hits[i][1]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Issue select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int t = 0; t < rs_pkg::NUM_FU_TYPES; t++) begin
			for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
				issue_req[t][i] = entry_ready[i]
					& (rs_table[i].fu_type == rs_pkg::fu_type_e'(t));
			end
		end
	end

	// k-th winner of a type lands on port FU_BASE + k
	for (genvar t = 0; t < rs_pkg::NUM_FU_TYPES; t++) begin : fu_gen
		prio_select #(
			.WIDTH      (rs_pkg::RS_SIZE),
			.NUM_GRANTS (rs_pkg::FU_PORTS[t])
		) issue_sel (
			.req         (issue_req[t]),
			.grant_idx   (sel_idx[rs_pkg::FU_BASE[t] +: rs_pkg::FU_PORTS[t]]),
			.grant_valid (sel_valid[rs_pkg::FU_BASE[t] +: rs_pkg::FU_PORTS[t]])
		);
	end

	// Issued copy shows both operands ready
	always_comb begin
		for (int p = 0; p < rs_pkg::NUM_ISSUE; p++) begin
			issue_entry_next[p]            = rs_table[sel_idx[p]];
			issue_entry_next[p].busy       = 1'b1;
			issue_entry_next[p].src1.ready = 1'b1;
			issue_entry_next[p].src2.ready = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Dispatch placement
	//////////////////////////////////////////////////////////////////////

	assign free_vec = ~busy_q;

	prio_select #(
		.WIDTH      (rs_pkg::RS_SIZE),
		.NUM_GRANTS (rs_pkg::DISPATCH_WIDTH)
	) dispatch_sel (
		.req         (free_vec),
		.grant_idx   (disp_idx),
		.grant_valid (disp_valid)
	);

	// Grants go to valid slots in slot order, so an idle slot
	// does not use up a free entry
	always_comb begin
		logic [rs_pkg::SLOT_BITS-1:0] rank;

		rank = '0;
		for (int s = 0; s < rs_pkg::DISPATCH_WIDTH; s++) begin
			slot_idx[s]        = disp_idx[rank];
			dispatch_accept[s] = dispatch[s].valid & ~flush & disp_valid[rank];
			if (dispatch[s].valid) begin
				rank = rank + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next table
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		busy_next     = busy_q;
		rs_table_next = rs_table;

		// Store wakeups
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			rs_table_next[i].src1.ready = rs_table[i].src1.ready | cam_hits[i][0];
			rs_table_next[i].src2.ready = rs_table[i].src2.ready | cam_hits[i][1];
		end

		// Free issued entries
		for (int p = 0; p < rs_pkg::NUM_ISSUE; p++) begin
			if (sel_valid[p]) begin
				busy_next[sel_idx[p]] = 1'b0;
			end
		end

		// Write accepted slots, only ever into free entries
		for (int s = 0; s < rs_pkg::DISPATCH_WIDTH; s++) begin
			if (dispatch_accept[s]) begin
				busy_next[slot_idx[s]]          = 1'b1;
				rs_table_next[slot_idx[s]]      = dispatch[s].entry;
				rs_table_next[slot_idx[s]].busy = 1'b1;
			end
		end
	end

	always_comb begin
		free_next = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			free_next = free_next + {{(rs_pkg::COUNT_BITS-1){1'b0}}, ~busy_next[i]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy_q        <= '0;
			issue_valid_q <= '0;
			free_count    <= rs_pkg::COUNT_BITS'(rs_pkg::RS_SIZE);
		end else if (flush) begin
			busy_q        <= '0;
			issue_valid_q <= '0;
			free_count    <= rs_pkg::COUNT_BITS'(rs_pkg::RS_SIZE);
		end else begin
			busy_q        <= busy_next;
			issue_valid_q <= sel_valid;
			free_count    <= free_next;
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		rs_table      <= rs_table_next;
		issue_entry_q <= issue_entry_next;
	end

	always_comb begin
		for (int p = 0; p < rs_pkg::NUM_ISSUE; p++) begin
			issue[p].valid = issue_valid_q[p];
			issue[p].entry = issue_entry_q[p];
		end
	end

endmodule

// File: hdl/rs_pkg.sv
// Shared sizes and unit-type codes for the reservation station
// Entry, dispatch, broadcast and issue structs

package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	// Table entries and per-cycle widths
	localparam int RS_SIZE        = 8;
	localparam int DISPATCH_WIDTH = 2;
	localparam int CDB_WIDTH      = 2;

	// Physical register tag width
	localparam int TAG_BITS = 6;

	// Decode stand-in field widths
	localparam int OPCODE_BITS = 8;
	localparam int NPC_BITS    = 16;

	// Derived index and count widths
	localparam int IDX_BITS   = $clog2(RS_SIZE);
	localparam int SLOT_BITS  = (DISPATCH_WIDTH > 1) ? $clog2(DISPATCH_WIDTH) : 1;
	localparam int COUNT_BITS = $clog2(RS_SIZE + 1);

	//////////////////////////////////////////////////////////////////////
	// Functional units
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_FU_TYPES = 3;
	localparam int NUM_ISSUE    = 4;

	// Ports per type and first issue port of each type
	// Order is ALU, MUL, MEM
	localparam int FU_PORTS [NUM_FU_TYPES] = '{2, 1, 1};
	localparam int FU_BASE  [NUM_FU_TYPES] = '{0, 2, 3};

	typedef enum logic [1:0] {
		FU_ALU = 2'd0,
		FU_MUL = 2'd1,
		FU_MEM = 2'd2
	} fu_type_e;

	//////////////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////////////

	// Source operand tag and its ready flag
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic                ready;
	} src_opnd_t;

	// One table entry
	typedef struct packed {
		logic                   busy;
		fu_type_e               fu_type;
		logic [TAG_BITS-1:0]    dest_tag;
		src_opnd_t              src1;
		src_opnd_t              src2;
		logic [OPCODE_BITS-1:0] opcode;
		logic [NPC_BITS-1:0]    npc;
	} rs_entry_t;

	// Dispatch slot, busy of the payload is don't care
	typedef struct packed {
		logic      valid;
		rs_entry_t entry;
	} dispatch_slot_t;

	// One common data bus lane
	typedef struct packed {
		logic                valid;
		logic [TAG_BITS-1:0] tag;
	} cdb_lane_t;

	// One issue port
	typedef struct packed {
		logic      valid;
		rs_entry_t entry;
	} issue_slot_t;

endpackage

// File: hdl/rs_top.sv
// Top level of the issue block
// Joins dispatch, broadcast, flush and issue ports to the station

`timescale 1ns/10ps

module rs_top (
	input  logic                                              clock,
	input  logic                                              rst_n,
	input  logic                                              flush,
	input  logic                                              issue_en,
	input  rs_pkg::dispatch_slot_t [rs_pkg::DISPATCH_WIDTH-1:0] dispatch,
	input  rs_pkg::cdb_lane_t [rs_pkg::CDB_WIDTH-1:0]           cdb,
	output logic [rs_pkg::DISPATCH_WIDTH-1:0]                   dispatch_accept,
	output rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0]         issue,
	output logic [rs_pkg::COUNT_BITS-1:0]                       free_count
);

	//////////////////////////////////////////////////////////////////////
	// Station
	//////////////////////////////////////////////////////////////////////

	// Dispatch accept is combinational, issue and free count are registered
	reservation_station rs_i (
		.clock           (clock),
		.rst_n           (rst_n),
		.flush           (flush),
		.issue_en        (issue_en),
		.dispatch        (dispatch),
		.cdb             (cdb),
		.dispatch_accept (dispatch_accept),
		.issue           (issue),
		.free_count      (free_count)
	);

endmodule

// File: hdl/tag_cam.sv
// Tag CAM for operand wakeup
// Compares both source tags of every entry against all broadcast lanes

`timescale 1ns/10ps

module tag_cam #(
	parameter int ENTRIES = 8,
	parameter int LANES   = 2
) (
	input  logic [ENTRIES-1:0][1:0][rs_pkg::TAG_BITS-1:0] entry_tags,
	input  rs_pkg::cdb_lane_t [LANES-1:0]                  cdb,
	output logic [ENTRIES-1:0][1:0]                        hits
);

	//////////////////////////////////////////////////////////////////////
	// Parallel compare
	//////////////////////////////////////////////////////////////////////

	// Operand 0 is src1, operand 1 is src2
	always_comb begin
		hits = '0;

		for (int e = 0; e < ENTRIES; e++) begin
			for (int o = 0; o < 2; o++) begin
				// Any valid lane carrying the tag wakes the operand
				for (int l = 0; l < LANES; l++) begin
					if (cdb[l].valid && (cdb[l].tag == entry_tags[e][o])) begin
						hits[e][o] = 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log

verilator --binary --timing -j 0 --top-module rs_tb -f sources.f -o rs_sim \
	> build.log 2>&1 \
	&& ./obj_dir/rs_sim > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q "TB FAILED" sim.log \
	&& grep -q "TB PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: sources.f
hdl/rs_pkg.sv
hdl/prio_select.sv
hdl/tag_cam.sv
hdl/reservation_station.sv
hdl/rs_top.sv
test/tb_clock_gen.sv
test/rs_checker.sv
test/rs_tb.sv

// File: test/rs_checker.sv
// Port checker for the reservation station
// Compares dispatch accepts, issue ports and free count with expected values

`timescale 1ns/10ps

module rs_checker (
	input  logic                                        clock,
	input  logic                                        check_en,
	input  logic [rs_pkg::DISPATCH_WIDTH-1:0]           dispatch_accept,
	input  rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0] issue,
	input  logic [rs_pkg::COUNT_BITS-1:0]               free_count,
	input  logic [rs_pkg::DISPATCH_WIDTH-1:0]           exp_accept,
	input  rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0] exp_issue,
	input  logic [rs_pkg::COUNT_BITS-1:0]               exp_free,
	output int                                          error_count
);

	int errors = 0;

	assign error_count = errors;

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// Payload fields only matter on a valid port
	task automatic check_issue_port(input int p);
		string             port;
		rs_pkg::rs_entry_t exp_e;
		rs_pkg::rs_entry_t act_e;

		port  = $sformatf("issue[%0d]", p);
		exp_e = exp_issue[p].entry;
		act_e = issue[p].entry;
		compare_value({port, ".valid"}, 32'(exp_issue[p].valid), 32'(issue[p].valid));
		if (exp_issue[p].valid) begin
			compare_value({port, ".dest_tag"}, 32'(exp_e.dest_tag), 32'(act_e.dest_tag));
			compare_value({port, ".fu_type"}, 32'(exp_e.fu_type), 32'(act_e.fu_type));
			compare_value({port, ".opcode"}, 32'(exp_e.opcode), 32'(act_e.opcode));
			compare_value({port, ".npc"}, 32'(exp_e.npc), 32'(act_e.npc));
			compare_value({port, ".src1.tag"}, 32'(exp_e.src1.tag), 32'(act_e.src1.tag));
			compare_value({port, ".src2.tag"}, 32'(exp_e.src2.tag), 32'(act_e.src2.tag));
			compare_value({port, ".src1.ready"}, 32'(exp_e.src1.ready), 32'(act_e.src1.ready));
			compare_value({port, ".src2.ready"}, 32'(exp_e.src2.ready), 32'(act_e.src2.ready));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampling
	//////////////////////////////////////////////////////////////////////

	// Accept is combinational, so it is sampled before the rising edge;
	// registered outputs just before the next falling edge
	always begin
		@(negedge clock);
		#2;
		if (check_en) begin
			compare_value("dispatch_accept", 32'(exp_accept), 32'(dispatch_accept));
			@(posedge clock);
			#3;
			for (int p = 0; p < rs_pkg::NUM_ISSUE; p++) begin
				check_issue_port(p);
			end
			compare_value("free_count", 32'(exp_free), 32'(free_count));
		end
	end

endmodule

// File: test/rs_tb.sv
// Top testbench for the reservation station
// Stimulus table with expected values, falling-edge drive and timeout

`timescale 1ns/10ps

module rs_tb;

	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_MARGIN = 40;

	// One table row
	// Tag 0 marks an idle slot, lane or port
	typedef struct packed {
		logic [rs_pkg::TAG_BITS-1:0]                        disp0;
		logic [rs_pkg::TAG_BITS-1:0]                        disp1;
		logic [rs_pkg::TAG_BITS-1:0]                        cdb0;
		logic [rs_pkg::TAG_BITS-1:0]                        cdb1;
		logic                                               flush;
		logic                                               issue_en;
		logic [rs_pkg::DISPATCH_WIDTH-1:0]                  accept;
		logic [rs_pkg::NUM_ISSUE-1:0][rs_pkg::TAG_BITS-1:0] port_tag;
		logic [rs_pkg::COUNT_BITS-1:0]                      free;
	} row_t;

	logic clock;
	logic rst_n;
	logic flush;
	logic issue_en;
	logic check_en;

	rs_pkg::dispatch_slot_t [rs_pkg::DISPATCH_WIDTH-1:0] dispatch;
	rs_pkg::cdb_lane_t [rs_pkg::CDB_WIDTH-1:0]           cdb;
	logic [rs_pkg::DISPATCH_WIDTH-1:0]                   dispatch_accept;
	rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0]         issue;
	logic [rs_pkg::COUNT_BITS-1:0]                       free_count;

	logic [rs_pkg::DISPATCH_WIDTH-1:0]           exp_accept;
	rs_pkg::issue_slot_t [rs_pkg::NUM_ISSUE-1:0] exp_issue;
	logic [rs_pkg::COUNT_BITS-1:0]               exp_free;

	// Instructions indexed by dest tag
	rs_pkg::rs_entry_t pool [2**rs_pkg::TAG_BITS];
	row_t              rows [$];

	int error_count;
	int cycle_count    = 0;
	int timeout_limit  = 0;
	int timeout_errors = 0;

	tb_clock_gen #(
		.PERIOD_NS    (8),
		.RESET_CYCLES (RESET_CYCLES)
	) clock_i (
		.clock (clock),
		.rst_n (rst_n)
	);

	rs_top dut_i (
		.clock           (clock),
		.rst_n           (rst_n),
		.flush           (flush),
		.issue_en        (issue_en),
		.dispatch        (dispatch),
		.cdb             (cdb),
		.dispatch_accept (dispatch_accept),
		.issue           (issue),
		.free_count      (free_count)
	);

	rs_checker checker_i (
		.clock           (clock),
		.check_en        (check_en),
		.dispatch_accept (dispatch_accept),
		.issue           (issue),
		.free_count      (free_count),
		.exp_accept      (exp_accept),
		.exp_issue       (exp_issue),
		.exp_free        (exp_free),
		.error_count     (error_count)
	);

	task automatic define_instr(input int tag, input rs_pkg::fu_type_e fu,
		input int t1, input int r1, input int t2, input int r2);
		rs_pkg::rs_entry_t e;

		e            = '0;
		e.fu_type    = fu;
		e.dest_tag   = rs_pkg::TAG_BITS'(tag);
		e.src1.tag   = rs_pkg::TAG_BITS'(t1);
		e.src1.ready = (r1 != 0);
		e.src2.tag   = rs_pkg::TAG_BITS'(t2);
		e.src2.ready = (r2 != 0);
		e.opcode     = rs_pkg::OPCODE_BITS'($urandom());
		e.npc        = rs_pkg::NPC_BITS'($urandom());
		pool[e.dest_tag] = e;
	endtask

	task automatic add_row(input int d0, d1, c0, c1, fl, en, acc, p0, p1, p2, p3, fc);
		row_t r;

		r.disp0       = rs_pkg::TAG_BITS'(d0);
		r.disp1       = rs_pkg::TAG_BITS'(d1);
		r.cdb0        = rs_pkg::TAG_BITS'(c0);
		r.cdb1        = rs_pkg::TAG_BITS'(c1);
		r.flush       = (fl != 0);
		r.issue_en    = (en != 0);
		r.accept      = rs_pkg::DISPATCH_WIDTH'(acc);
		r.port_tag[0] = rs_pkg::TAG_BITS'(p0);
		r.port_tag[1] = rs_pkg::TAG_BITS'(p1);
		r.port_tag[2] = rs_pkg::TAG_BITS'(p2);
		r.port_tag[3] = rs_pkg::TAG_BITS'(p3);
		r.free        = rs_pkg::COUNT_BITS'(fc);
		rows.push_back(r);
	endtask

	function automatic rs_pkg::dispatch_slot_t make_slot(input logic [rs_pkg::TAG_BITS-1:0] tag);
		rs_pkg::dispatch_slot_t slot;

		slot = '0;
		if (tag != '0) begin
			slot.valid = 1'b1;
			slot.entry = pool[tag];
		end
		return slot;
	endfunction

	function automatic rs_pkg::cdb_lane_t make_lane(input logic [rs_pkg::TAG_BITS-1:0] tag);
		rs_pkg::cdb_lane_t lane;

		lane.valid = (tag != '0);
		lane.tag   = tag;
		return lane;
	endfunction

	// Issued copy is marked busy with both operands ready
	function automatic rs_pkg::issue_slot_t expect_issue(input logic [rs_pkg::TAG_BITS-1:0] tag);
		rs_pkg::issue_slot_t s;

		s = '0;
		if (tag != '0) begin
			s.valid            = 1'b1;
			s.entry            = pool[tag];
			s.entry.busy       = 1'b1;
			s.entry.src1.ready = 1'b1;
			s.entry.src2.ready = 1'b1;
		end
		return s;
	endfunction

	task automatic apply_row(input row_t r);
		dispatch[0] = make_slot(r.disp0);
		dispatch[1] = make_slot(r.disp1);
		cdb[0]      = make_lane(r.cdb0);
		cdb[1]      = make_lane(r.cdb1);
		flush       = r.flush;
		issue_en    = r.issue_en;
		exp_accept  = r.accept;
		for (int p = 0; p < rs_pkg::NUM_ISSUE; p++) begin
			exp_issue[p] = expect_issue(r.port_tag[p]);
		end
		exp_free = r.free;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// Tags 40 to 45 are never broadcast
		define_instr(1, rs_pkg::FU_ALU, 40, 1, 41, 1);
		define_instr(2, rs_pkg::FU_ALU, 42, 1, 43, 1);
		define_instr(3, rs_pkg::FU_MUL, 42, 1, 17, 0);
		define_instr(4, rs_pkg::FU_ALU, 40, 1, 41, 1);
		define_instr(5, rs_pkg::FU_ALU, 40, 1, 41, 1);
		define_instr(6, rs_pkg::FU_ALU, 40, 1, 41, 1);
		define_instr(7, rs_pkg::FU_MEM, 44, 1, 45, 1);
		for (int t = 8; t <= 18; t++) begin
			if (t != 17) begin
				define_instr(t, rs_pkg::FU_ALU, 50, 0, 40, 1);
			end
		end

		// d0  d1  c0  c1 fl en acc  p0  p1 p2 p3 free
		add_row( 1,  2,  0,  0, 0, 1, 3,  0,  0, 0, 0, 6);
		add_row( 0,  0,  0,  0, 0, 1, 0,  1,  2, 0, 0, 8);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 8);
		// Idle slot 0 does not waste the free entry
		add_row( 0,  3,  0,  0, 0, 1, 2,  0,  0, 0, 0, 7);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 7);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 7);
		add_row( 0,  0,  0, 17, 0, 1, 0,  0,  0, 3, 0, 8);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 8);
		// ALU contention with a MEM entry alongside
		add_row( 4,  5,  0,  0, 0, 1, 3,  0,  0, 0, 0, 6);
		add_row( 6,  7,  0,  0, 0, 0, 3,  0,  0, 0, 0, 4);
		add_row( 0,  0,  0,  0, 0, 1, 0,  4,  5, 0, 7, 7);
		add_row( 0,  0,  0,  0, 0, 1, 0,  6,  0, 0, 0, 8);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 8);
		// Fill the table with entries waiting on tag 50
		add_row( 8,  9,  0,  0, 0, 1, 3,  0,  0, 0, 0, 6);
		add_row(10, 11,  0,  0, 0, 1, 3,  0,  0, 0, 0, 4);
		add_row(12, 13,  0,  0, 0, 1, 3,  0,  0, 0, 0, 2);
		add_row(14,  0,  0,  0, 0, 1, 1,  0,  0, 0, 0, 1);
		add_row(15, 16,  0,  0, 0, 1, 1,  0,  0, 0, 0, 0);
		add_row(16, 18,  0,  0, 0, 1, 0,  0,  0, 0, 0, 0);
		// Stall with a wakeup, then release, then flush
		add_row( 0,  0, 50,  0, 0, 0, 0,  0,  0, 0, 0, 0);
		add_row( 0,  0,  0,  0, 0, 0, 0,  0,  0, 0, 0, 0);
		add_row( 0,  0,  0,  0, 0, 1, 0,  8,  9, 0, 0, 2);
		add_row(16,  0,  0,  0, 1, 1, 0,  0,  0, 0, 0, 8);
		add_row( 0,  0, 50, 17, 0, 1, 0,  0,  0, 0, 0, 8);
		add_row( 0,  0,  0,  0, 0, 1, 0,  0,  0, 0, 0, 8);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h271c));
		dispatch   = '0;
		cdb        = '0;
		flush      = 1'b0;
		issue_en   = 1'b0;
		check_en   = 1'b0;
		exp_accept = '0;
		exp_issue  = '0;
		exp_free   = '0;
		build_table();
		timeout_limit = RESET_CYCLES + rows.size() + TIMEOUT_MARGIN;

		@(posedge rst_n);
		foreach (rows[i]) begin
			@(negedge clock);
			check_en = 1'b1;
			apply_row(rows[i]);
		end
		@(negedge clock);
		check_en = 1'b0;
		dispatch = '0;
		cdb      = '0;
		flush    = 1'b0;
		repeat (2) @(negedge clock);

		$display("Errors: %0d compare, %0d timeout", error_count, timeout_errors);
		if (error_count == 0 && timeout_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	always @(posedge clock) begin
		if (timeout_limit > 0) begin
			cycle_count = cycle_count + 1;
			if (cycle_count >= timeout_limit) begin
				$display("Timeout: the run did not end within %0d cycles", timeout_limit);
				timeout_errors = timeout_errors + 1;
				$display("Errors: %0d compare, %0d timeout", error_count, timeout_errors);
				$display("TB FAILED");
				$finish;
			end
		end
	end

endmodule

// File: test/tb_clock_gen.sv
// Clock and reset source for the testbench

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Release on a falling edge, away from the active edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule
